// ==== bench/tb_mxint_dot_product.sv ====
`timescale 1ns/100ps

module tb_mxint_dot_product
  import mxint_pkg::*;
;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  // five register stages, the first one loaded on the transfer edge.
  localparam int PIPE_LATENCY = 4;
  localparam int DRAIN_CYCLES = 100;
  localparam int TOTAL_BLOCKS = 1 + 4 + 200 + 200 + 12;
  localparam int WATCHDOG_CYCLES = 200 * TOTAL_BLOCKS + 500;

  logic     clk;
  logic     rst_n;
  man_vec_t mdata_in;
  exp_t     edata_in;
  logic     data_in_valid;
  logic     data_in_ready;
  man_vec_t mweight;
  exp_t     eweight;
  logic     weight_valid;
  logic     weight_ready;
  acc_t     mdata_out;
  out_exp_t edata_out;
  logic     data_out_valid;
  logic     data_out_ready;

  // blocks waiting to be driven, and results still owed by the DUT.
  man_vec_t act_man_q[$];
  exp_t     act_exp_q[$];
  man_vec_t wgt_man_q[$];
  exp_t     wgt_exp_q[$];
  acc_t     exp_man_q[$];
  out_exp_t exp_exp_q[$];

  string test_name;
  bit    stall_seen;
  bit    sending;

  mxint_dot_product dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .mdata_in       (mdata_in),
    .edata_in       (edata_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .mweight        (mweight),
    .eweight        (eweight),
    .weight_valid   (weight_valid),
    .weight_ready   (weight_ready),
    .mdata_out      (mdata_out),
    .edata_out      (edata_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic stop_on_failure();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  // --------------------
  // reference model
  // --------------------

  function automatic int full_mantissa(input man_vec_t a, input man_vec_t w);
    int sum;
    sum = 0;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      sum += int'(a[i]) * int'(w[i]);
    end
    return sum;
  endfunction

  function automatic acc_t ref_mantissa(input man_vec_t a, input man_vec_t w);
    return acc_t'(full_mantissa(a, w));
  endfunction

  function automatic out_exp_t ref_exponent(input exp_t ea, input exp_t ew);
    return out_exp_t'(int'(ea) + int'(ew));
  endfunction

  function automatic man_vec_t random_vec();
    man_vec_t v;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      v[i] = man_t'($urandom);
    end
    return v;
  endfunction

  function automatic man_vec_t fill_vec(input man_t m);
    man_vec_t v;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      v[i] = m;
    end
    return v;
  endfunction

  task automatic queue_pair(input man_vec_t am, input exp_t ae, input man_vec_t wm,
                            input exp_t we);
    act_man_q.push_back(am);
    act_exp_q.push_back(ae);
    wgt_man_q.push_back(wm);
    wgt_exp_q.push_back(we);
    exp_man_q.push_back(ref_mantissa(am, wm));
    exp_exp_q.push_back(ref_exponent(ae, we));
  endtask

  // the exact result must fit the result widths without wrapping.
  task automatic queue_extreme(input man_vec_t am, input exp_t ae, input man_vec_t wm,
                               input exp_t we);
    int man_sum;
    int exp_sum;
    man_sum = full_mantissa(am, wm);
    exp_sum = int'(ae) + int'(we);
    if (int'(acc_t'(man_sum)) != man_sum || int'(out_exp_t'(exp_sum)) != exp_sum) begin
      $display("the exact result in %s does not fit the result widths", test_name);
      stop_on_failure();
    end
    queue_pair(am, ae, wm, we);
  endtask

  // --------------------
  // checks
  // --------------------

  task automatic check_mantissa(input acc_t expected, input acc_t actual);
    if (actual !== expected) begin
      $display("Error in %s: mantissa expected %0d, actual %0d", test_name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_exponent(input out_exp_t expected, input out_exp_t actual);
    if (actual !== expected) begin
      $display("Error in %s: exponent expected %0d, actual %0d", test_name, expected, actual);
      stop_on_failure();
    end
  endtask

  // outputs sampled mid-cycle, where they are stable.
  always @(negedge clk) begin
    if (rst_n) begin
      if (data_in_valid && !data_in_ready && data_out_valid && !data_out_ready) begin
        stall_seen = 1'b1;
      end
      if (data_out_valid && data_out_ready) begin
        if (exp_man_q.size() == 0) begin
          $display("the DUT sent a result with no block pair outstanding");
          stop_on_failure();
        end else begin
          check_mantissa(exp_man_q.pop_front(), mdata_out);
          check_exponent(exp_exp_q.pop_front(), edata_out);
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before all tests finished");
    stop_on_failure();
  end

  // --------------------
  // drivers
  // --------------------

  task automatic drive_acts(input int start_delay);
    if (start_delay > 0) begin
      repeat (start_delay) @(posedge clk);
      #1;
    end
    while (act_man_q.size() > 0) begin
      mdata_in      = act_man_q.pop_front();
      edata_in      = act_exp_q.pop_front();
      data_in_valid = 1'b1;
      @(negedge clk);
      while (!data_in_ready) begin
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      data_in_valid = 1'b0;
    end
  endtask

  task automatic drive_weights(input int start_delay);
    if (start_delay > 0) begin
      repeat (start_delay) @(posedge clk);
      #1;
    end
    while (wgt_man_q.size() > 0) begin
      mweight      = wgt_man_q.pop_front();
      eweight      = wgt_exp_q.pop_front();
      weight_valid = 1'b1;
      @(negedge clk);
      while (!weight_ready) begin
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      weight_valid = 1'b0;
    end
  endtask

  task automatic run_drivers(input int act_delay, input int wgt_delay);
    fork
      drive_acts(act_delay);
      drive_weights(wgt_delay);
    join
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_man_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  // --------------------
  // tests
  // --------------------

  task automatic test_single_block();
    man_vec_t a;
    man_vec_t w;
    int       cycles;
    test_name = "test_single_block";
    a = {man_t'(-3), man_t'(7), man_t'(-100), man_t'(25)};
    w = {man_t'(11), man_t'(-9), man_t'(-4), man_t'(60)};
    queue_pair(a, exp_t'(-5), w, exp_t'(12));
    run_drivers(0, 0);
    cycles = 0;
    while (!data_out_valid && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cycles != PIPE_LATENCY) begin
      $display("Error in %s: latency expected %0d, actual %0d", test_name, PIPE_LATENCY,
               cycles);
      stop_on_failure();
    end
    wait_drain();
  endtask

  task automatic test_extremes();
    test_name = "test_extremes";
    queue_extreme(fill_vec(man_t'(-128)), exp_t'(-128), fill_vec(man_t'(-128)), exp_t'(-128));
    queue_extreme(fill_vec(man_t'(127)), exp_t'(127), fill_vec(man_t'(127)), exp_t'(127));
    queue_extreme(fill_vec(man_t'(-128)), exp_t'(127), fill_vec(man_t'(127)), exp_t'(-128));
    queue_extreme(fill_vec(man_t'(127)), exp_t'(-128), fill_vec(man_t'(-128)), exp_t'(127));
    run_drivers(0, 0);
    wait_drain();
  endtask

  task automatic test_stream();
    test_name = "test_stream";
    for (int n = 0; n < 200; n++) begin
      queue_pair(random_vec(), exp_t'($urandom), random_vec(), exp_t'($urandom));
    end
    run_drivers(0, 0);
    wait_drain();
  endtask

  task automatic test_backpressure();
    test_name = "test_backpressure";
    for (int n = 0; n < 200; n++) begin
      queue_pair(random_vec(), exp_t'($urandom), random_vec(), exp_t'($urandom));
    end
    data_out_ready = 1'b0;
    stall_seen     = 1'b0;
    sending        = 1'b1;
    fork
      begin
        run_drivers(0, 0);
        sending = 1'b0;
      end
      begin
        // output held long enough to fill every stage.
        repeat (30) @(posedge clk);
        #1;
        if (!stall_seen) begin
          $display("input ready did not fall while the output was held");
          stop_on_failure();
        end
        while (sending) begin
          data_out_ready = ($urandom % 2) == 0;
          @(posedge clk);
          #1;
        end
        data_out_ready = 1'b1;
      end
    join
    wait_drain();
  endtask

  task automatic test_skew();
    test_name = "test_skew";
    for (int n = 0; n < 6; n++) begin
      queue_pair(random_vec(), exp_t'($urandom), random_vec(), exp_t'($urandom));
    end
    run_drivers(0, 10);
    wait_drain();
    for (int n = 0; n < 6; n++) begin
      queue_pair(random_vec(), exp_t'($urandom), random_vec(), exp_t'($urandom));
    end
    run_drivers(10, 0);
    wait_drain();
  endtask

  initial begin
    void'($urandom(15508));
    rst_n          = 1'b0;
    mdata_in       = '0;
    edata_in       = '0;
    data_in_valid  = 1'b0;
    mweight        = '0;
    eweight        = '0;
    weight_valid   = 1'b0;
    data_out_ready = 1'b1;
    stall_seen     = 1'b0;
    sending        = 1'b0;
    test_name      = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    if (!data_in_ready || !weight_ready || data_out_valid) begin
      $display("handshake outputs are wrong after reset");
      stop_on_failure();
    end
    rst_n = 1'b1;

    test_single_block();
    test_extremes();
    test_stream();
    test_backpressure();
    test_skew();

    if (exp_man_q.size() != 0) begin
      $display("%0d expected results never arrived", exp_man_q.size());
      stop_on_failure();
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// ==== compile.f ====
source/mxint_pkg.sv
source/mxint_split.sv
source/fixed_dot_product.sv
source/mxint_result_join.sv
source/mxint_dot_product.sv
bench/tb_mxint_dot_product.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f compile.f \
  --top-module tb_mxint_dot_product -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_mxint_dot_product)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== source/fixed_dot_product.sv ====
`timescale 1ns/100ps

module fixed_dot_product
  import mxint_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  man_vec_t data_in,
  input  logic     data_in_valid,
  output logic     data_in_ready,
  input  man_vec_t weight,
  input  logic     weight_valid,
  output logic     weight_ready,
  output acc_t     data_out,
  output logic     data_out_valid,
  input  logic     data_out_ready
);

  typedef logic signed [PROD_WIDTH-1:0] prod_t;

  prod_t prod_q [BLOCK_SIZE];
  acc_t  sum_q  [BLOCK_SIZE/2];
  acc_t  tree_sum;
  acc_t  acc_q;
  logic  v1_q;
  logic  v2_q;
  logic  v3_q;
  logic  stall;
  logic  advance;
  logic  in_fire;

  // one stall for every stage, from the output handshake.
  assign stall   = v3_q && !data_out_ready;
  assign advance = !stall;

  // both operands enter together.
  assign data_in_ready = advance && weight_valid;
  assign weight_ready  = advance && data_in_valid;
  assign in_fire       = data_in_valid && weight_valid && advance;

  // --------------------
  // valid chain
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
      v3_q <= 1'b0;
    end else if (advance) begin
      v1_q <= in_fire;
      v2_q <= v1_q;
      v3_q <= v2_q;
    end
  end

  // --------------------
  // datapath
  // --------------------

  // last level adds the pair sums.
  always_comb begin
    tree_sum = '0;
    for (int j = 0; j < BLOCK_SIZE / 2; j++) begin
      tree_sum = tree_sum + sum_q[j];
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      // stage 1, signed products.
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        prod_q[i] <= $signed(data_in[i]) * $signed(weight[i]);
      end
      // stage 2, pairwise sums, sign extended.
      for (int j = 0; j < BLOCK_SIZE / 2; j++) begin
        sum_q[j] <= acc_t'(prod_q[2*j]) + acc_t'(prod_q[2*j+1]);
      end
      // stage 3.
      acc_q <= tree_sum;
    end
  end

  assign data_out       = acc_q;
  assign data_out_valid = v3_q;

endmodule

// ==== source/mxint_dot_product.sv ====
`timescale 1ns/100ps

module mxint_dot_product
  import mxint_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // activation block.
  input  man_vec_t mdata_in,
  input  exp_t     edata_in,
  input  logic     data_in_valid,
  output logic     data_in_ready,
  // weight block.
  input  man_vec_t mweight,
  input  exp_t     eweight,
  input  logic     weight_valid,
  output logic     weight_ready,
  // result.
  output acc_t     mdata_out,
  output out_exp_t edata_out,
  output logic     data_out_valid,
  input  logic     data_out_ready
);

  man_vec_t act_man;
  logic     act_man_valid;
  logic     act_man_ready;
  exp_t     act_exp;
  logic     act_exp_valid;
  logic     act_exp_ready;

  man_vec_t weight_man;
  logic     weight_man_valid;
  logic     weight_man_ready;
  exp_t     weight_exp;
  logic     weight_exp_valid;
  logic     weight_exp_ready;

  acc_t     fdp_out;
  logic     fdp_out_valid;
  logic     fdp_out_ready;

  // --------------------
  // input side
  // --------------------

  mxint_split act_split_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .mdata_in      (mdata_in),
    .edata_in      (edata_in),
    .data_in_valid (data_in_valid),
    .data_in_ready (data_in_ready),
    .man_out       (act_man),
    .man_out_valid (act_man_valid),
    .man_out_ready (act_man_ready),
    .exp_out       (act_exp),
    .exp_out_valid (act_exp_valid),
    .exp_out_ready (act_exp_ready)
  );

  mxint_split weight_split_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .mdata_in      (mweight),
    .edata_in      (eweight),
    .data_in_valid (weight_valid),
    .data_in_ready (weight_ready),
    .man_out       (weight_man),
    .man_out_valid (weight_man_valid),
    .man_out_ready (weight_man_ready),
    .exp_out       (weight_exp),
    .exp_out_valid (weight_exp_valid),
    .exp_out_ready (weight_exp_ready)
  );

  // --------------------
  // mantissa arithmetic
  // --------------------

  fixed_dot_product fdp_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in        (act_man),
    .data_in_valid  (act_man_valid),
    .data_in_ready  (act_man_ready),
    .weight         (weight_man),
    .weight_valid   (weight_man_valid),
    .weight_ready   (weight_man_ready),
    .data_out       (fdp_out),
    .data_out_valid (fdp_out_valid),
    .data_out_ready (fdp_out_ready)
  );

  // --------------------
  // output side
  // --------------------

  mxint_result_join join_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .man_in         (fdp_out),
    .man_in_valid   (fdp_out_valid),
    .man_in_ready   (fdp_out_ready),
    .exp_a          (act_exp),
    .exp_a_valid    (act_exp_valid),
    .exp_a_ready    (act_exp_ready),
    .exp_w          (weight_exp),
    .exp_w_valid    (weight_exp_valid),
    .exp_w_ready    (weight_exp_ready),
    .mdata_out      (mdata_out),
    .edata_out      (edata_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

endmodule

// ==== source/mxint_pkg.sv ====
package mxint_pkg;

  // --------------------
  // block geometry
  // --------------------

  // mantissas per block.
  localparam int BLOCK_SIZE = 4;

  // input element widths.
  localparam int MAN_WIDTH = 8;
  localparam int EXP_WIDTH = 8;

  // one mantissa product, before any addition.
  localparam int PROD_WIDTH = 2 * MAN_WIDTH;

  // exact sum of BLOCK_SIZE products.
  localparam int ACC_WIDTH = PROD_WIDTH + $clog2(BLOCK_SIZE);

  // sum of two signed exponents needs one extra bit.
  localparam int OUT_EXP_WIDTH = EXP_WIDTH + 1;

  // exponent queue, deep enough for the mantissa path in flight.
  localparam int EXP_FIFO_DEPTH = 8;
  localparam int EXP_PTR_WIDTH  = $clog2(EXP_FIFO_DEPTH);

  // --------------------
  // element types
  // --------------------

  typedef logic signed [MAN_WIDTH-1:0] man_t;

  // element 0 sits in the low bits.
  typedef man_t [BLOCK_SIZE-1:0] man_vec_t;

  typedef logic signed [EXP_WIDTH-1:0] exp_t;

  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  typedef logic signed [OUT_EXP_WIDTH-1:0] out_exp_t;

endpackage

// ==== source/mxint_result_join.sv ====
`timescale 1ns/100ps

module mxint_result_join
  import mxint_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  acc_t     man_in,
  input  logic     man_in_valid,
  output logic     man_in_ready,
  input  exp_t     exp_a,
  input  logic     exp_a_valid,
  output logic     exp_a_ready,
  input  exp_t     exp_w,
  input  logic     exp_w_valid,
  output logic     exp_w_ready,
  output acc_t     mdata_out,
  output out_exp_t edata_out,
  output logic     data_out_valid,
  input  logic     data_out_ready
);

  acc_t     man_q;
  out_exp_t exp_q;
  logic     valid_q;
  logic     all_valid;
  logic     can_load;
  logic     join_fire;

  assign all_valid = man_in_valid && exp_a_valid && exp_w_valid;

  // free now or emptied this cycle.
  assign can_load  = !valid_q || data_out_ready;
  assign join_fire = all_valid && can_load;

  // pop all three inputs together.
  assign man_in_ready = join_fire;
  assign exp_a_ready  = join_fire;
  assign exp_w_ready  = join_fire;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (can_load) begin
      valid_q <= all_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (join_fire) begin
      man_q <= man_in;
      exp_q <= out_exp_t'(exp_a) + out_exp_t'(exp_w);
    end
  end

  assign mdata_out      = man_q;
  assign edata_out      = exp_q;
  assign data_out_valid = valid_q;

endmodule

// ==== source/mxint_split.sv ====
`timescale 1ns/100ps

module mxint_split
  import mxint_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  man_vec_t mdata_in,
  input  exp_t     edata_in,
  input  logic     data_in_valid,
  output logic     data_in_ready,
  output man_vec_t man_out,
  output logic     man_out_valid,
  input  logic     man_out_ready,
  output exp_t     exp_out,
  output logic     exp_out_valid,
  input  logic     exp_out_ready
);

  man_vec_t man_q;
  logic     man_valid_q;
  logic     man_free;

  exp_t                     exp_mem [EXP_FIFO_DEPTH];
  logic [EXP_PTR_WIDTH-1:0] wr_ptr_q;
  logic [EXP_PTR_WIDTH-1:0] rd_ptr_q;
  logic [EXP_PTR_WIDTH:0]   count_q;
  logic                     exp_full;
  logic                     exp_push;
  logic                     exp_pop;
  logic                     accept;

  // a block needs room on both sides.
  assign man_free      = !man_valid_q || man_out_ready;
  assign exp_full      = (count_q == (EXP_PTR_WIDTH + 1)'(EXP_FIFO_DEPTH));
  assign data_in_ready = man_free && !exp_full;
  assign accept        = data_in_valid && data_in_ready;

  // --------------------
  // mantissa stage
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      man_valid_q <= 1'b0;
    end else if (man_free) begin
      man_valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      man_q <= mdata_in;
    end
  end

  assign man_out       = man_q;
  assign man_out_valid = man_valid_q;

  // --------------------
  // exponent queue
  // --------------------

  assign exp_push = accept;
  assign exp_pop  = exp_out_valid && exp_out_ready;

  always_ff @(posedge clk) begin
    if (exp_push) begin
      exp_mem[wr_ptr_q] <= edata_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (exp_push) begin
        wr_ptr_q <= (wr_ptr_q == EXP_PTR_WIDTH'(EXP_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (exp_pop) begin
        rd_ptr_q <= (rd_ptr_q == EXP_PTR_WIDTH'(EXP_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({exp_push, exp_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // head entry read straight from the storage flops.
  assign exp_out       = exp_mem[rd_ptr_q];
  assign exp_out_valid = (count_q != '0);

endmodule
